// File: verilog.f
common/cpuPkg.sv
decode/instrDecoder.sv
execute/alu.sv
logic/registerFile.sv
logic/loadStoreUnit.sv
logic/cpu.sv
verif/cpu_assert.sv
verif/cpuTb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - common/cpuPkg.sv
  - decode/instrDecoder.sv
  - execute/alu.sv
  - logic/registerFile.sv
  - logic/loadStoreUnit.sv
  - logic/cpu.sv
  - target: test
    files:
      - verif/cpu_assert.sv
      - verif/cpuTb.sv

// File: verif/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic        we;
        logic [2:0]  group;
    } step_t;

    localparam int MAX_STEPS = 96;
    localparam int TIMEOUT_NS = 100;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] memRdData;
    logic [31:0] pc;
    logic [31:0] memAddr;
    logic [31:0] memWrData;
    logic [3:0]  memMask;
    logic        memWE;

    logic [31:0] imem [0:127];
    logic [31:0] dmem [0:63];
    step_t       stepTable [0:MAX_STEPS-1];
    int          stepCount;
    logic [2:0]  curGroup;
    int          cycleCount;
    time         lastEdge;
    int          checks;
    int          errors;

    cpu u_dut (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .memRdData(memRdData),
        .pc(pc),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memMask(memMask),
        .memWE(memWE)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        lastEdge = $time;
    end

    // data memory, combinational read and byte-masked write
    assign memRdData = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memWE) begin
            for (int b = 0; b < 4; b++) begin
                if (memMask[b]) begin
                    dmem[memAddr[7:2]][b*8 +: 8] <= memWrData[b*8 +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] op);
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic string groupName(input logic [2:0] g);
        case (g)
            3'd1:    return "reset and straight-line flow";
            3'd2:    return "ALU results";
            3'd3:    return "store sizes and offsets";
            3'd4:    return "load extraction";
            3'd5:    return "branches and jumps";
            default: return "x0 and unsupported opcode";
        endcase
    endfunction

    task automatic addStep(input logic [31:0] instr, input logic [31:0] nextPc,
                           input logic we, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] mask);
        stepTable[stepCount] = {instr, nextPc, addr, data, mask, we, curGroup};
        stepCount++;
    endtask

    task automatic addPlain(input logic [31:0] instr, input logic [31:0] nextPc);
        addStep(instr, nextPc, 1'b0, 32'h0, 32'h0, 4'h0);
    endtask

    // sw xN, 0xc0(x0) with the value that xN must hold
    task automatic addResultStore(input int rs2, input logic [31:0] nextPc,
                                  input logic [31:0] value);
        addStep(sType(12'h0c0, rs2, 0, 3'd2), nextPc, 1'b1, 32'hc0, value, 4'hf);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    task automatic waitCycle();
        int target;
        int waited;
        target = cycleCount + 1;
        waited = 0;
        while (cycleCount < target && waited < TIMEOUT_NS) begin
            #1;
            waited++;
        end
        if (cycleCount < target) begin
            $display("timeout: no rising clock edge within %0d ns", TIMEOUT_NS);
            $display("Test failed");
            $finish;
        end else if ($time < lastEdge + 1) begin
            #(lastEdge + 1 - $time);
        end
    endtask

    task automatic buildProgram();
        curGroup = 3'd1;
        addPlain(iType(12'hffb, 0, 3'd0, 1, 7'h13), 32'd4);
        addPlain(iType(12'h007, 0, 3'd0, 2, 7'h13), 32'd8);
        addPlain(iType(12'h080, 0, 3'd0, 10, 7'h13), 32'd12);
        curGroup = 3'd2;
        addPlain(rType(7'h00, 2, 1, 3'd0, 3), 32'd16);
        addResultStore(3, 32'd20, 32'h00000002);
        addPlain(rType(7'h20, 2, 1, 3'd0, 3), 32'd24);
        addResultStore(3, 32'd28, 32'hfffffff4);
        addPlain(rType(7'h00, 2, 1, 3'd2, 3), 32'd32);
        addResultStore(3, 32'd36, 32'h00000001);
        addPlain(rType(7'h00, 2, 1, 3'd3, 3), 32'd40);
        addResultStore(3, 32'd44, 32'h00000000);
        addPlain(rType(7'h20, 2, 1, 3'd5, 3), 32'd48);
        addResultStore(3, 32'd52, 32'hffffffff);
        addPlain(rType(7'h00, 2, 1, 3'd5, 3), 32'd56);
        addResultStore(3, 32'd60, 32'h01ffffff);
        addPlain(rType(7'h00, 2, 1, 3'd4, 3), 32'd64);
        addResultStore(3, 32'd68, 32'hfffffffc);
        addPlain(rType(7'h00, 2, 1, 3'd6, 3), 32'd72);
        addResultStore(3, 32'd76, 32'hffffffff);
        addPlain(rType(7'h00, 2, 1, 3'd7, 3), 32'd80);
        addResultStore(3, 32'd84, 32'h00000003);
        addPlain(iType(12'h0f0, 1, 3'd4, 3, 7'h13), 32'd88);
        addResultStore(3, 32'd92, 32'hffffff0b);
        addPlain(iType(12'hffc, 1, 3'd2, 3, 7'h13), 32'd96);
        addResultStore(3, 32'd100, 32'h00000001);
        addPlain(iType(12'hfff, 2, 3'd3, 3, 7'h13), 32'd104);
        addResultStore(3, 32'd108, 32'h00000001);
        addPlain(iType(12'h401, 1, 3'd5, 3, 7'h13), 32'd112);
        addResultStore(3, 32'd116, 32'hfffffffd);
        addPlain(iType(12'h004, 2, 3'd1, 3, 7'h13), 32'd120);
        addResultStore(3, 32'd124, 32'h00000070);
        addPlain({20'h12345, 5'd4, 7'h37}, 32'd128);
        addResultStore(4, 32'd132, 32'h12345000);
        addPlain({20'h00001, 5'd5, 7'h17}, 32'd136);
        addResultStore(5, 32'd140, 32'h00001084);
        curGroup = 3'd3;
        addPlain({20'ha1b2c, 5'd6, 7'h37}, 32'd144);
        addPlain(iType(12'h3d4, 6, 3'd0, 6, 7'h13), 32'd148);
        addStep(sType(12'h0c1, 6, 0, 3'd0), 32'd152, 1'b1, 32'hc1, 32'hb2c3d400, 4'b0010);
        addStep(sType(12'h0c3, 6, 0, 3'd0), 32'd156, 1'b1, 32'hc3, 32'hd4000000, 4'b1000);
        addStep(sType(12'h0c0, 6, 0, 3'd0), 32'd160, 1'b1, 32'hc0, 32'ha1b2c3d4, 4'b0001);
        addStep(sType(12'h0c2, 6, 0, 3'd0), 32'd164, 1'b1, 32'hc2, 32'hc3d40000, 4'b0100);
        addStep(sType(12'h0c2, 6, 0, 3'd1), 32'd168, 1'b1, 32'hc2, 32'hc3d40000, 4'b1100);
        addStep(sType(12'h0c0, 6, 0, 3'd1), 32'd172, 1'b1, 32'hc0, 32'ha1b2c3d4, 4'b0011);
        addStep(sType(12'h0c4, 6, 0, 3'd2), 32'd176, 1'b1, 32'hc4, 32'ha1b2c3d4, 4'b1111);
        curGroup = 3'd4;
        addPlain(iType(12'h001, 10, 3'd0, 7, 7'h03), 32'd180);
        addResultStore(7, 32'd184, 32'hfffffff0);
        addPlain(iType(12'h003, 10, 3'd4, 7, 7'h03), 32'd188);
        addResultStore(7, 32'd192, 32'h0000008b);
        addPlain(iType(12'h002, 10, 3'd1, 7, 7'h03), 32'd196);
        addResultStore(7, 32'd200, 32'hffff8bad);
        addPlain(iType(12'h000, 10, 3'd5, 7, 7'h03), 32'd204);
        addResultStore(7, 32'd208, 32'h0000f00d);
        addPlain(iType(12'h004, 10, 3'd2, 7, 7'h03), 32'd212);
        addResultStore(7, 32'd216, 32'h0000ff80);
        addPlain(iType(12'h004, 10, 3'd1, 7, 7'h03), 32'd220);
        addResultStore(7, 32'd224, 32'hffffff80);
        addPlain(iType(12'h004, 10, 3'd4, 7, 7'h03), 32'd228);
        addResultStore(7, 32'd232, 32'h00000080);
        curGroup = 3'd5;
        addPlain(bType(13'd8, 2, 1, 3'd0), 32'd236);
        addPlain(bType(13'd8, 2, 1, 3'd1), 32'd244);
        addPlain(bType(13'd8, 2, 1, 3'd4), 32'd252);
        addPlain(bType(13'd8, 2, 1, 3'd5), 32'd256);
        addPlain(bType(13'd8, 2, 1, 3'd6), 32'd260);
        addPlain(bType(13'd8, 2, 1, 3'd7), 32'd268);
        addPlain(bType(13'd12, 1, 2, 3'd5), 32'd280);
        addPlain(jType(21'd12, 11), 32'd292);
        addResultStore(11, 32'd296, 32'd284);
        addPlain(iType(12'h139, 0, 3'd0, 12, 7'h13), 32'd300);
        // target 317 lands on 316
        addPlain(iType(12'h004, 12, 3'd0, 13, 7'h67), 32'd316);
        addResultStore(13, 32'd320, 32'd304);
        // opposite outcome of each kind above
        addPlain(bType(13'd8, 1, 1, 3'd0), 32'd328);
        addPlain(bType(13'd8, 1, 1, 3'd1), 32'd332);
        addPlain(bType(13'd8, 1, 2, 3'd4), 32'd336);
        addPlain(bType(13'd8, 1, 2, 3'd6), 32'd344);
        addPlain(bType(13'd8, 1, 2, 3'd7), 32'd348);
        curGroup = 3'd6;
        addPlain(iType(12'h037, 0, 3'd0, 0, 7'h13), 32'd352);
        addResultStore(0, 32'd356, 32'h00000000);
        // unsupported opcode whose rd field names x3
        addPlain(32'hfffff1ff, 32'd360);
        addResultStore(3, 32'd364, 32'h00000070);
        addPlain(iType(12'h0c0, 0, 3'd2, 8, 7'h03), 32'd368);
        addResultStore(8, 32'd372, 32'h00000070);
    endtask

    initial begin
        logic [31:0] expectedPc;
        logic [31:0] fillAddr;
        int          groupErrors;
        step_t       s;

        void'($urandom(32'ha24c9101));
        reset       = 1'b1;
        // a store held on the bus while reset is high
        instruction = sType(12'h0c0, 0, 0, 3'd2);
        cycleCount  = 0;
        lastEdge    = 0;
        checks      = 0;
        errors      = 0;
        stepCount   = 0;

        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom;
        end
        dmem[32'h80 >> 2] = 32'h8badf00d;
        dmem[32'h84 >> 2] = 32'h0000ff80;

        buildProgram();
        for (int i = 0; i < 128; i++) begin
            imem[i] = 32'h00000013;
        end
        // place each instruction at the address it runs from
        fillAddr = 32'h0;
        for (int i = 0; i < stepCount; i++) begin
            imem[fillAddr[8:2]] = stepTable[i].instr;
            fillAddr = stepTable[i].nextPc;
        end

        for (int i = 0; i < 10; i++) begin
            waitCycle();
            checkValue("memWE", 32'h0, {31'h0, memWE});
        end
        reset = 1'b0;

        expectedPc  = 32'h0;
        groupErrors = 0;
        for (int i = 0; i < stepCount; i++) begin
            s = stepTable[i];
            checkValue("pc", expectedPc, pc);
            instruction = imem[pc[8:2]];
            #3;
            checkValue("memWE", {31'h0, s.we}, {31'h0, memWE});
            if (s.we) begin
                checkValue("memAddr", s.addr, memAddr);
                checkValue("memWrData", s.data, memWrData);
                checkValue("memMask", {28'h0, s.mask}, {28'h0, memMask});
            end
            waitCycle();
            expectedPc = s.nextPc;
            if (i == stepCount - 1 || stepTable[i+1].group != s.group) begin
                checkValue("pc", expectedPc, pc);
                $display("%s: %0d errors", groupName(s.group), errors - groupErrors);
                groupErrors = errors;
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/cpu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module cpuAssert (
    input logic        clk,
    input logic        reset,
    input logic [31:0] pc,
    input logic        memWE,
    input logic [3:0]  memMask
);

    noStoreInReset: assert property (@(posedge clk) reset |-> !memWE)
        else $error("memWE high during reset");

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    // byte, halfword or word lanes only
    legalMask: assert property (@(posedge clk) disable iff (reset)
        memWE |-> memMask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                  4'b0011, 4'b1100, 4'b1111})
        else $error("illegal memMask %b", memMask);

endmodule

bind cpu cpuAssert assertInst (
    .clk(clk),
    .reset(reset),
    .pc(pc),
    .memWE(memWE),
    .memMask(memMask)
);

`default_nettype wire

// File: logic/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::word_t instruction,
    input  cpuPkg::word_t memRdData,
    output cpuPkg::word_t pc,
    output cpuPkg::word_t memAddr,
    output cpuPkg::word_t memWrData,
    output logic [3:0]    memMask,
    output logic          memWE
);
    import cpuPkg::*;

    ctrl_t ctrl;
    word_t imm;
    word_t rs1Data;
    word_t rs2Data;
    word_t op1;
    word_t op2;
    word_t aluResult;
    word_t loadData;
    word_t pcPlus4;
    word_t pcPlusImm;
    word_t writeback;
    word_t nextPc;
    logic  branchTaken;

    instrDecoder decoderInst (
        .reset(reset),
        .instruction(instruction),
        .ctrl(ctrl),
        .imm(imm)
    );

    registerFile regFileInst (
        .clk(clk),
        .rs1Addr(instruction[19:15]),
        .rs2Addr(instruction[24:20]),
        .rdAddr(instruction[11:7]),
        .rdData(writeback),
        .we(ctrl.regWE),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    assign op1 = ctrl.src1IsPc ? pc : rs1Data;
    assign op2 = ctrl.src2IsImm ? imm : rs2Data;

    alu aluInst (
        .op1(op1),
        .op2(op2),
        .aluOp(ctrl.aluOp),
        .branchKind(ctrl.branchKind),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    loadStoreUnit lsuInst (
        .addr(aluResult),
        .storeData(rs2Data),
        .memRdData(memRdData),
        .memSize(ctrl.memSize),
        .loadUnsigned(ctrl.loadUnsigned),
        .memWrData(memWrData),
        .memMask(memMask),
        .loadData(loadData)
    );

    assign memAddr = aluResult;
    assign memWE   = ctrl.memWE;

    assign pcPlus4   = pc + 32'd4;
    assign pcPlusImm = pc + imm;

    always_comb begin
        case (ctrl.resultSel)
            ALU:     writeback = aluResult;
            LOAD:    writeback = loadData;
            PC4:     writeback = pcPlus4;
            default: writeback = imm;
        endcase
    end

    // jalr clears bit 0 of its target
    always_comb begin
        if (ctrl.isJalr) begin
            nextPc = {aluResult[31:1], 1'b0};
        end else if (ctrl.isJal || (ctrl.isBranch && branchTaken)) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: logic/loadStoreUnit.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
    input  cpuPkg::word_t    addr,
    input  cpuPkg::word_t    storeData,
    input  cpuPkg::word_t    memRdData,
    input  cpuPkg::memSize_t memSize,
    input  logic             loadUnsigned,
    output cpuPkg::word_t    memWrData,
    output logic [3:0]       memMask,
    output cpuPkg::word_t    loadData
);
    import cpuPkg::*;

    logic [1:0] offset;
    logic [3:0] baseMask;
    logic [7:0] loadByte;
    logic [15:0] loadHalf;

    assign offset = addr[1:0];

    // store side: data and mask move to the addressed lanes
    assign memWrData = storeData << {offset, 3'b000};
    assign memMask   = baseMask << offset;

    always_comb begin
        case (memSize)
            BYTE:    baseMask = 4'b0001;
            HALF:    baseMask = 4'b0011;
            default: baseMask = 4'b1111;
        endcase
    end

    // load side
    always_comb begin
        case (offset)
            2'b00:   loadByte = memRdData[7:0];
            2'b01:   loadByte = memRdData[15:8];
            2'b10:   loadByte = memRdData[23:16];
            default: loadByte = memRdData[31:24];
        endcase
    end

    assign loadHalf = offset[1] ? memRdData[31:16] : memRdData[15:0];

    always_comb begin
        case (memSize)
            BYTE:    loadData = {{24{loadByte[7] & ~loadUnsigned}}, loadByte};
            HALF:    loadData = {{16{loadHalf[15] & ~loadUnsigned}}, loadHalf};
            WORD:    loadData = memRdData;
            default: loadData = memRdData;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic             clk,
    input  cpuPkg::regAddr_t rs1Addr,
    input  cpuPkg::regAddr_t rs2Addr,
    input  cpuPkg::regAddr_t rdAddr,
    input  cpuPkg::word_t    rdData,
    input  logic             we,
    output cpuPkg::word_t    rs1Data,
    output cpuPkg::word_t    rs2Data
);
    import cpuPkg::*;

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (we && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpuPkg::word_t       op1,
    input  cpuPkg::word_t       op2,
    input  cpuPkg::aluOp_t      aluOp,
    input  cpuPkg::branchKind_t branchKind,
    output cpuPkg::word_t       result,
    output logic                branchTaken
);
    import cpuPkg::*;

    logic [4:0] shamt;
    logic       isEqual;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = op2[4:0];
    assign isEqual      = (op1 == op2);
    assign lessSigned   = ($signed(op1) < $signed(op2));
    assign lessUnsigned = (op1 < op2);

    always_comb begin
        case (aluOp)
            ADD:     result = op1 + op2;
            SUB:     result = op1 - op2;
            SLL:     result = op1 << shamt;
            SLT:     result = {31'b0, lessSigned};
            SLTU:    result = {31'b0, lessUnsigned};
            XOR:     result = op1 ^ op2;
            SRL:     result = op1 >> shamt;
            SRA:     result = word_t'($signed(op1) >>> shamt);
            OR:      result = op1 | op2;
            AND:     result = op1 & op2;
            PASSB:   result = op2;
            default: result = '0;
        endcase
    end

    // branchKind is the branch funct3
    always_comb begin
        case (branchKind)
            3'b000:  branchTaken = isEqual;
            3'b001:  branchTaken = !isEqual;
            3'b100:  branchTaken = lessSigned;
            3'b101:  branchTaken = !lessSigned;
            3'b110:  branchTaken = lessUnsigned;
            3'b111:  branchTaken = !lessUnsigned;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: decode/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  logic           reset,
    input  cpuPkg::word_t  instruction,
    output cpuPkg::ctrl_t  ctrl,
    output cpuPkg::word_t  imm
);
    import cpuPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;
    word_t      immShamt;

    // funct3 to ALU op; alt selects SUB or SRA
    function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
        aluOp_t op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign opcode   = instruction[6:0];
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];

    assign immI     = {{20{instruction[31]}}, instruction[31:20]};
    assign immS     = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB     = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
    assign immU     = {instruction[31:12], 12'b0};
    assign immJ     = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
    assign immShamt = {27'b0, instruction[24:20]};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        ctrl.aluOp = ADD;
        ctrl.resultSel = ALU;
        case (opcode)
            OPC_LUI: begin
                ctrl.aluOp     = PASSB;
                ctrl.src2IsImm = 1'b1;
                ctrl.regWE     = 1'b1;
                ctrl.resultSel = IMM;
                imm            = immU;
            end
            OPC_AUIPC: begin
                ctrl.src1IsPc  = 1'b1;
                ctrl.src2IsImm = 1'b1;
                ctrl.regWE     = 1'b1;
                imm            = immU;
            end
            OPC_JAL: begin
                ctrl.isJal     = 1'b1;
                ctrl.regWE     = 1'b1;
                ctrl.resultSel = PC4;
                imm            = immJ;
            end
            OPC_JALR: begin
                ctrl.isJalr    = 1'b1;
                ctrl.src2IsImm = 1'b1;
                ctrl.regWE     = 1'b1;
                ctrl.resultSel = PC4;
                imm            = immI;
            end
            OPC_BRANCH: begin
                ctrl.isBranch   = 1'b1;
                ctrl.branchKind = funct3;
                ctrl.aluOp      = SUB;
                imm             = immB;
            end
            OPC_LOAD: begin
                ctrl.src2IsImm    = 1'b1;
                ctrl.regWE        = 1'b1;
                ctrl.resultSel    = LOAD;
                ctrl.memSize      = memSize_t'(funct3[1:0]);
                ctrl.loadUnsigned = funct3[2];
                imm               = immI;
            end
            OPC_STORE: begin
                ctrl.src2IsImm = 1'b1;
                ctrl.memWE     = 1'b1;
                ctrl.memSize   = memSize_t'(funct3[1:0]);
                imm            = immS;
            end
            OPC_OPIMM: begin
                ctrl.src2IsImm = 1'b1;
                ctrl.regWE     = 1'b1;
                // only shifts take funct7, there is no SUBI
                ctrl.aluOp     = aluFromFunct(funct3, funct7b5 && funct3 == 3'b101);
                imm            = (funct3[1:0] == 2'b01) ? immShamt : immI;
            end
            OPC_OP: begin
                ctrl.regWE = 1'b1;
                ctrl.aluOp = aluFromFunct(funct3, funct7b5);
            end
            default: begin
                // unsupported opcode runs as a no-op
                ctrl.regWE = 1'b0;
            end
        endcase
        if (reset) begin
            ctrl.memWE = 1'b0;
            ctrl.regWE = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [3:0] aluOp_t;
    typedef logic [2:0] branchKind_t;
    typedef logic [1:0] resultSel_t;
    typedef logic [1:0] memSize_t;

    localparam aluOp_t ADD   = 4'd0;
    localparam aluOp_t SUB   = 4'd1;
    localparam aluOp_t SLL   = 4'd2;
    localparam aluOp_t SLT   = 4'd3;
    localparam aluOp_t SLTU  = 4'd4;
    localparam aluOp_t XOR   = 4'd5;
    localparam aluOp_t SRL   = 4'd6;
    localparam aluOp_t SRA   = 4'd7;
    localparam aluOp_t OR    = 4'd8;
    localparam aluOp_t AND   = 4'd9;
    localparam aluOp_t PASSB = 4'd10;

    // writeback sources
    localparam resultSel_t ALU  = 2'd0;
    localparam resultSel_t LOAD = 2'd1;
    localparam resultSel_t PC4  = 2'd2;
    localparam resultSel_t IMM  = 2'd3;

    // same encoding as funct3[1:0] of loads and stores
    localparam memSize_t BYTE = 2'd0;
    localparam memSize_t HALF = 2'd1;
    localparam memSize_t WORD = 2'd2;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef struct packed {
        aluOp_t      aluOp;
        logic        src1IsPc;
        logic        src2IsImm;
        logic        regWE;
        resultSel_t  resultSel;
        logic        memWE;
        memSize_t    memSize;
        logic        loadUnsigned;
        logic        isBranch;
        branchKind_t branchKind;
        logic        isJal;
        logic        isJalr;
    } ctrl_t;

endpackage

`default_nettype wire
